// ==== include/pgm_ddram_settings.svh ====
`ifndef PGM_DDRAM_SETTINGS_SVH
`define PGM_DDRAM_SETTINGS_SVH

// Read clients sharing the port: CPU ROM, video fetch, audio samples
`define PGM_NUM_CLIENTS 3

// DDRAM side
`define PGM_ADDR_W 29       // 64-bit word address
`define PGM_DATA_W 64
`define PGM_BE_W 8          // One enable per byte of the data word

// Loader side
`define PGM_IOCTL_ADDR_W 27 // Byte address from the HPS
`define PGM_IOCTL_DATA_W 16

// Image index that goes into DDRAM, others are ignored here
`define PGM_LOADER_INDEX 0

`endif

// ==== hw/pgm_ddram_pkg.sv ====
`include "pgm_ddram_settings.svh"

package pgm_ddram_pkg;

    typedef logic [1:0] client_idx_t;   // Room for four clients

    // Level request from one client, addr held stable while req is high
    typedef struct packed {
        logic                   req;
        logic [`PGM_ADDR_W-1:0] addr;
    } read_req_t;

    // Granted read, arbiter to sequencer
    typedef struct packed {
        logic                   valid;  // Held until the completion
        client_idx_t            client;
        logic [`PGM_ADDR_W-1:0] addr;
    } read_cmd_t;

    // One-cycle completion broadcast to every slot
    typedef struct packed {
        logic                   valid;
        client_idx_t            client; // Slot that owns this data
        logic [`PGM_DATA_W-1:0] data;
    } read_done_t;

    // Latched loader write
    typedef struct packed {
        logic                   pending; // Also the wait back to the HPS
        logic [`PGM_ADDR_W-1:0] addr;
        logic [`PGM_DATA_W-1:0] data;
        logic [`PGM_BE_W-1:0]   be;
    } write_cmd_t;

    // Return path to a client
    typedef struct packed {
        logic                   ack;    // Level, drops after req drops
        logic [`PGM_DATA_W-1:0] data;
    } read_resp_t;

endpackage

// ==== hw/read_slot.sv ====
`timescale 1ns/1ns
`include "pgm_ddram_settings.svh"

// Holds one client's read until it completes, then keeps ack up until
// the client lets go of req
module read_slot #(
    parameter pgm_ddram_pkg::client_idx_t slot_index = '0  // Matched against done.client
) (
    input  logic                      fixed_50m_clk,
    input  logic                      reset,
    input  pgm_ddram_pkg::read_req_t  request,
    input  pgm_ddram_pkg::read_done_t done,
    output logic                      pending,
    output logic [`PGM_ADDR_W-1:0]    pending_addr,
    output pgm_ddram_pkg::read_resp_t response
);

    logic                   ack;
    logic [`PGM_DATA_W-1:0] ack_data;
    logic                   take_req;   // New request accepted this cycle
    logic                   done_hit;   // Completion belongs to this slot

    // No new request while ack is still up or one is already queued
    assign take_req = request.req && !ack && !pending;
    assign done_hit = done.valid && (done.client == slot_index) && pending;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            pending <= 1'b0;
            ack     <= 1'b0;
        end else if (done_hit) begin
            pending <= 1'b0;
            ack     <= 1'b1;            // Data is valid from here on
        end else begin
            if (take_req)
                pending <= 1'b1;
            if (!request.req)
                ack <= 1'b0;            // Client released, close the handshake
        end
    end

    // Address and returned word
    always_ff @(posedge fixed_50m_clk) begin
        if (take_req)
            pending_addr <= request.addr;   // Frozen for the arbiter
        if (done_hit)
            ack_data <= done.data;          // Full 64-bit word to every client
    end

    assign response = '{ack: ack, data: ack_data};

endmodule

// ==== hw/grant_arbiter.sv ====
`timescale 1ns/1ns
`include "pgm_ddram_settings.svh"

// Fixed priority, lowest client index wins. Only one read in flight,
// the grant stays until its completion comes back
module grant_arbiter (
    input  logic                      fixed_50m_clk,
    input  logic                      reset,
    input  logic                      download,
    input  logic                      pending [`PGM_NUM_CLIENTS],
    input  logic [`PGM_ADDR_W-1:0]    pending_addr [`PGM_NUM_CLIENTS],
    input  pgm_ddram_pkg::read_done_t done,
    output pgm_ddram_pkg::read_cmd_t  command
);

    logic                       pick_found;
    pgm_ddram_pkg::client_idx_t pick_client;
    logic [`PGM_ADDR_W-1:0]     pick_addr;
    logic                       grant_valid;
    pgm_ddram_pkg::client_idx_t grant_client;
    logic [`PGM_ADDR_W-1:0]     grant_addr;
    logic                       grant_take;
    logic                       grant_done;

    // Scan from the top down so the lowest pending index is left standing
    always_comb begin
        pick_found  = 1'b0;
        pick_client = '0;
        pick_addr   = '0;
        for (int i = `PGM_NUM_CLIENTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick_found  = 1'b1;
                pick_client = pgm_ddram_pkg::client_idx_t'(i);
                pick_addr   = pending_addr[i];
            end
        end
    end

    // New grants are held off while the loader owns the port
    assign grant_take = !grant_valid && !download && pick_found;
    assign grant_done = grant_valid && done.valid && (done.client == grant_client);

    always_ff @(posedge fixed_50m_clk) begin
        if (reset)
            grant_valid <= 1'b0;
        else if (grant_done)
            grant_valid <= 1'b0;    // Slot clears its pending on the same edge
        else if (grant_take)
            grant_valid <= 1'b1;
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (grant_take) begin
            grant_client <= pick_client;
            grant_addr   <= pick_addr;
        end
    end

    assign command = '{valid: grant_valid, client: grant_client, addr: grant_addr};

endmodule

// ==== hw/loader_write_latch.sv ====
`timescale 1ns/1ns
`include "pgm_ddram_settings.svh"

// Turns one 16-bit loader write into a byte-masked 64-bit DDRAM write
// and keeps it until the controller takes it
module loader_write_latch (
    input  logic                          fixed_50m_clk,
    input  logic                          reset,
    input  logic                          ioctl_download,
    input  logic                          ioctl_wr,
    input  logic [`PGM_IOCTL_ADDR_W-1:0]  ioctl_addr,
    input  logic [`PGM_IOCTL_DATA_W-1:0]  ioctl_dout,
    input  logic [7:0]                    ioctl_index,
    input  logic                          ddram_busy,
    output pgm_ddram_pkg::write_cmd_t     write
);

    logic                   wr_pending;
    logic [`PGM_ADDR_W-1:0] wr_addr;
    logic [`PGM_DATA_W-1:0] wr_data;
    logic [`PGM_BE_W-1:0]   wr_be;
    logic                   wr_accept;

    // Only the DDRAM image, and only one write held at a time
    assign wr_accept = ioctl_wr && (ioctl_index == 8'(`PGM_LOADER_INDEX)) && !wr_pending;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download)
            wr_pending <= 1'b0;             // Nothing survives the end of a download
        else if (wr_accept)
            wr_pending <= 1'b1;
        else if (wr_pending && !ddram_busy)
            wr_pending <= 1'b0;             // Taken on the first non-busy clock
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (wr_accept) begin
            // Byte address to 64-bit word address
            wr_addr <= `PGM_ADDR_W'(ioctl_addr[`PGM_IOCTL_ADDR_W-1:3]);
            wr_data <= {(`PGM_DATA_W / `PGM_IOCTL_DATA_W){ioctl_dout}}; // Same halfword in every lane
            case (ioctl_addr[2:1])          // Halfword within the word picks the lane
                2'd0:    wr_be <= 8'h03;
                2'd1:    wr_be <= 8'h0C;
                2'd2:    wr_be <= 8'h30;
                default: wr_be <= 8'hC0;
            endcase
        end
    end

    assign write = '{pending: wr_pending, addr: wr_addr, data: wr_data, be: wr_be};

endmodule

// ==== hw/ddram_sequencer.sv ====
`timescale 1ns/1ns
`include "pgm_ddram_settings.svh"

// Drives the physical DDRAM port. Reads come from the arbiter, writes
// from the loader latch
module ddram_sequencer (
    input  logic                      fixed_50m_clk,
    input  logic                      reset,
    input  pgm_ddram_pkg::read_cmd_t  command,
    input  pgm_ddram_pkg::write_cmd_t write,
    input  logic                      ddram_busy,
    input  logic                      ddram_dout_ready,
    input  logic [`PGM_DATA_W-1:0]    ddram_dout,
    output logic                      ddram_rd,
    output logic                      ddram_we,
    output logic [`PGM_ADDR_W-1:0]    ddram_addr,
    output logic [`PGM_DATA_W-1:0]    ddram_din,
    output logic [`PGM_BE_W-1:0]      ddram_be,
    output pgm_ddram_pkg::read_done_t done,
    output logic                      ioctl_wait
);

    logic                       rd_issued;   // Current command already went out
    logic                       done_valid;
    pgm_ddram_pkg::client_idx_t done_client;
    logic [`PGM_DATA_W-1:0]     done_data;
    logic                       capture;

    // Single rd pulse per command. A pending write owns the address bus,
    // so the read waits behind it
    assign ddram_rd = command.valid && !rd_issued && !ddram_busy && !write.pending;

    // Only data for a read we actually issued, one completion per command
    assign capture = command.valid && rd_issued && ddram_dout_ready && !done_valid;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            rd_issued  <= 1'b0;
            done_valid <= 1'b0;
        end else begin
            done_valid <= capture;          // One-cycle strobe to the slots
            if (!command.valid)
                rd_issued <= 1'b0;          // Rearm once the grant is gone
            else if (ddram_rd)
                rd_issued <= 1'b1;
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (capture) begin
            done_client <= command.client;
            done_data   <= ddram_dout;
        end
    end

    assign done = '{valid: done_valid, client: done_client, data: done_data};

    // Write side straight from the latch
    assign ddram_we   = write.pending;
    assign ioctl_wait = write.pending;      // HPS stalls while a write is held
    assign ddram_din  = write.data;

    // Address and byte enables
    assign ddram_addr = write.pending ? write.addr : command.addr;
    assign ddram_be   = write.pending ? write.be : {`PGM_BE_W{1'b1}};  // Reads fetch the whole word

endmodule

// ==== hw/pgm_ddram_hub.sv ====
`timescale 1ns/1ns
`include "pgm_ddram_settings.svh"

// Memory-side hub: one DDRAM port shared by the ROM loader and the
// read clients, all on the 50 MHz clock
module pgm_ddram_hub (
    input  logic                          fixed_50m_clk,
    input  logic                          reset,

    // Loader
    input  logic                          ioctl_download,
    input  logic                          ioctl_wr,
    input  logic [`PGM_IOCTL_ADDR_W-1:0]  ioctl_addr,
    input  logic [`PGM_IOCTL_DATA_W-1:0]  ioctl_dout,
    input  logic [7:0]                    ioctl_index,
    output logic                          ioctl_wait,

    // Read clients, index 0 has top priority
    input  pgm_ddram_pkg::read_req_t      client_req  [`PGM_NUM_CLIENTS],
    output pgm_ddram_pkg::read_resp_t     client_resp [`PGM_NUM_CLIENTS],

    // DDRAM port
    output logic                          ddram_rd,
    output logic                          ddram_we,
    output logic [`PGM_ADDR_W-1:0]        ddram_addr,
    output logic [`PGM_DATA_W-1:0]        ddram_din,
    output logic [`PGM_BE_W-1:0]          ddram_be,
    input  logic [`PGM_DATA_W-1:0]        ddram_dout,
    input  logic                          ddram_busy,
    input  logic                          ddram_dout_ready
);

    pgm_ddram_pkg::write_cmd_t write;
    pgm_ddram_pkg::read_cmd_t  command;
    pgm_ddram_pkg::read_done_t done;
    logic                      slot_pending [`PGM_NUM_CLIENTS];
    logic [`PGM_ADDR_W-1:0]    slot_addr    [`PGM_NUM_CLIENTS];

    loader_write_latch loader_write_latch_i (
        .fixed_50m_clk  (fixed_50m_clk),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_index    (ioctl_index),
        .ddram_busy     (ddram_busy),
        .write          (write)
    );

    // One slot per client, all listening to the same completion bus
    for (genvar i = 0; i < `PGM_NUM_CLIENTS; i++) begin : slot_gen
        read_slot #(
            .slot_index (pgm_ddram_pkg::client_idx_t'(i))
        ) read_slot_i (
            .fixed_50m_clk (fixed_50m_clk),
            .reset         (reset),
            .request       (client_req[i]),
            .done          (done),
            .pending       (slot_pending[i]),
            .pending_addr  (slot_addr[i]),
            .response      (client_resp[i])
        );
    end

    grant_arbiter grant_arbiter_i (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .download      (ioctl_download),    // No new reads while loading
        .pending       (slot_pending),
        .pending_addr  (slot_addr),
        .done          (done),
        .command       (command)
    );

    ddram_sequencer ddram_sequencer_i (
        .fixed_50m_clk    (fixed_50m_clk),
        .reset            (reset),
        .command          (command),
        .write            (write),
        .ddram_busy       (ddram_busy),
        .ddram_dout_ready (ddram_dout_ready),
        .ddram_dout       (ddram_dout),
        .ddram_rd         (ddram_rd),
        .ddram_we         (ddram_we),
        .ddram_addr       (ddram_addr),
        .ddram_din        (ddram_din),
        .ddram_be         (ddram_be),
        .done             (done),
        .ioctl_wait       (ioctl_wait)
    );

endmodule

// ==== tb/pgm_ddram_hub_assertions.sv ====
`timescale 1ns/1ns
`include "pgm_ddram_settings.svh"

// Protocol checks on the ports of pgm_ddram_hub
module pgm_ddram_hub_assertions #(
    parameter logic [`PGM_DATA_W-1:0] resp_xor = 64'h5a5a_c3c3_0f0f_9669
) (
    input logic                             fixed_50m_clk,
    input logic                             reset,
    input logic                             ioctl_download,
    input logic                             ioctl_wr,
    input logic [`PGM_IOCTL_ADDR_W-1:0]     ioctl_addr,
    input logic [`PGM_IOCTL_DATA_W-1:0]     ioctl_dout,
    input logic [7:0]                       ioctl_index,
    input logic                             ioctl_wait,
    input pgm_ddram_pkg::read_req_t         client_req  [`PGM_NUM_CLIENTS],
    input pgm_ddram_pkg::read_resp_t        client_resp [`PGM_NUM_CLIENTS],
    input logic                             ddram_rd,
    input logic                             ddram_we,
    input logic [`PGM_ADDR_W-1:0]           ddram_addr,
    input logic [`PGM_DATA_W-1:0]           ddram_din,
    input logic [`PGM_BE_W-1:0]             ddram_be,
    input logic                             ddram_busy
);

    int                             fail_count = 0;     // Assertion failures so far
    int                             rd_outstanding;     // Reads issued and not yet acked
    logic [`PGM_NUM_CLIENTS-1:0]    req_vec;
    logic [`PGM_NUM_CLIENTS-1:0]    ack_vec;
    logic [`PGM_NUM_CLIENTS-1:0]    ack_q;
    logic                           req0_q;
    logic                           req2_q;
    logic                           idle_phase;        // No request or write since reset
    logic                           race_armed;        // Client 0 must win this race
    logic [`PGM_ADDR_W-1:0]         exp_addr;
    logic [`PGM_DATA_W-1:0]         exp_din;
    logic [`PGM_BE_W-1:0]           exp_be;
    logic                           wr_taken;

    always_comb begin
        for (int i = 0; i < `PGM_NUM_CLIENTS; i++) begin
            req_vec[i] = client_req[i].req;
            ack_vec[i] = client_resp[i].ack;
        end
    end

    assign wr_taken = ioctl_download && ioctl_wr && ioctl_index == 8'd0 && !ioctl_wait;

    always_ff @(posedge fixed_50m_clk) begin
        ack_q  <= ack_vec;
        req0_q <= client_req[0].req;
        req2_q <= client_req[2].req;
        if (reset)
            idle_phase <= 1'b1;
        else if (ioctl_wr || req_vec != '0)
            idle_phase <= 1'b0;                     // First request or write ends it
        if (reset)
            rd_outstanding <= 0;
        else
            rd_outstanding <= rd_outstanding + (ddram_rd ? 1 : 0) - ((|(ack_vec & ~ack_q)) ? 1 : 0);
        if (reset || ack_vec[0])
            race_armed <= 1'b0;
        else if (client_req[0].req && !req0_q && client_req[2].req && !req2_q
                 && rd_outstanding == 0 && ack_vec == '0 && !ddram_we)
            race_armed <= 1'b1;                     // Both rose together on an idle hub
        if (wr_taken) begin
            exp_addr <= `PGM_ADDR_W'(ioctl_addr >> 3);  // Byte to 64-bit word
            exp_din  <= {4{ioctl_dout}};
            exp_be   <= 8'h03 << (2 * ioctl_addr[2:1]);
        end
    end

    // Quiet outputs from reset until the first request or write
    assert property (@(posedge fixed_50m_clk) disable iff (reset) idle_phase |->
        !ddram_rd && !ddram_we && !ioctl_wait && ack_vec == '0)
        else begin
            fail_count++;
            $error("Outputs not idle after reset");
        end

    // Loader writes
    assert property (@(posedge fixed_50m_clk) disable iff (reset) wr_taken |=> ddram_we)
        else begin
            fail_count++;
            $error("Accepted loader write gave no ddram_we");
        end
    assert property (@(posedge fixed_50m_clk) disable iff (reset) ioctl_wait == ddram_we)
        else begin
            fail_count++;
            $error("FAILED ioctl_wait %h ddram_we %h", ioctl_wait, ddram_we);
        end
    assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_we |-> ddram_addr == exp_addr && ddram_din == exp_din && ddram_be == exp_be)
        else begin
            fail_count++;
            $error("FAILED ddram_addr %h/%h ddram_din %h/%h ddram_be %h/%h",
                   ddram_addr, exp_addr, ddram_din, exp_din, ddram_be, exp_be);
        end
    assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ioctl_wr && ioctl_index != 8'd0 && !ddram_we |=> !ddram_we)
        else begin
            fail_count++;
            $error("Write to another image index reached DDRAM");
        end

    // Read pulse rules
    assert property (@(posedge fixed_50m_clk) disable iff (reset) ddram_rd |-> !ddram_busy)
        else begin
            fail_count++;
            $error("ddram_rd issued while busy");
        end
    assert property (@(posedge fixed_50m_clk) disable iff (reset) ddram_rd |-> !ioctl_download)
        else begin
            fail_count++;
            $error("ddram_rd issued during download");
        end
    assert property (@(posedge fixed_50m_clk) disable iff (reset) ddram_rd |=> !ddram_rd)
        else begin
            fail_count++;
            $error("ddram_rd high on two cycles in a row");
        end
    assert property (@(posedge fixed_50m_clk) disable iff (reset) ddram_rd |-> ddram_be == 8'hff)
        else begin
            fail_count++;
            $error("FAILED ddram_be %h on read, expected ff", ddram_be);
        end
    assert property (@(posedge fixed_50m_clk) disable iff (reset) ddram_rd |-> rd_outstanding == 0)
        else begin
            fail_count++;
            $error("Second read issued before the first was acked");
        end
    assert property (@(posedge fixed_50m_clk) disable iff (reset)
        |(ack_vec & ~ack_q) |-> rd_outstanding == 1)
        else begin
            fail_count++;
            $error("FAILED rd_outstanding %h at ack", rd_outstanding);
        end

    // Client 0 beats client 2
    assert property (@(posedge fixed_50m_clk) disable iff (reset) race_armed |-> !ack_vec[2])
        else begin
            fail_count++;
            $error("Client 2 acked before client 0");
        end

    for (genvar i = 0; i < `PGM_NUM_CLIENTS; i++) begin : client_chk
        assert property (@(posedge fixed_50m_clk) disable iff (reset)
            $rose(client_resp[i].ack) |->
            client_resp[i].data == ({35'd0, client_req[i].addr} ^ resp_xor))
            else begin
                fail_count++;
                $error("FAILED client_resp[%0d].data %h expected %h", i, client_resp[i].data,
                       {35'd0, client_req[i].addr} ^ resp_xor);
            end
        assert property (@(posedge fixed_50m_clk) disable iff (reset)
            client_resp[i].ack && client_req[i].req |=> client_resp[i].ack)
            else begin
                fail_count++;
                $error("Ack of client %0d dropped while req high", i);
            end
        assert property (@(posedge fixed_50m_clk) disable iff (reset)
            client_resp[i].ack && !client_req[i].req |=> !client_resp[i].ack)
            else begin
                fail_count++;
                $error("Ack of client %0d stayed after req fell", i);
            end
    end

endmodule

bind pgm_ddram_hub pgm_ddram_hub_assertions checks_i (
    .fixed_50m_clk  (fixed_50m_clk),
    .reset          (reset),
    .ioctl_download (ioctl_download),
    .ioctl_wr       (ioctl_wr),
    .ioctl_addr     (ioctl_addr),
    .ioctl_dout     (ioctl_dout),
    .ioctl_index    (ioctl_index),
    .ioctl_wait     (ioctl_wait),
    .client_req     (client_req),
    .client_resp    (client_resp),
    .ddram_rd       (ddram_rd),
    .ddram_we       (ddram_we),
    .ddram_addr     (ddram_addr),
    .ddram_din      (ddram_din),
    .ddram_be       (ddram_be),
    .ddram_busy     (ddram_busy)
);

// ==== tb/tb_pgm_ddram_hub.sv ====
`timescale 1ns/1ns
`include "pgm_ddram_settings.svh"

module tb_pgm_ddram_hub;

    localparam logic [`PGM_DATA_W-1:0] RESP_XOR = 64'h5a5a_c3c3_0f0f_9669; // Responder data key
    localparam int TIMEOUT = 300;               // Cycles per wait

    logic                               fixed_50m_clk;
    logic                               reset;
    logic                               ioctl_download, ioctl_wr;
    logic [`PGM_IOCTL_ADDR_W-1:0]       ioctl_addr;
    logic [`PGM_IOCTL_DATA_W-1:0]       ioctl_dout;
    logic [7:0]                         ioctl_index;
    logic                               ioctl_wait;
    pgm_ddram_pkg::read_req_t           client_req  [`PGM_NUM_CLIENTS];
    pgm_ddram_pkg::read_resp_t          client_resp [`PGM_NUM_CLIENTS];
    logic                               ddram_rd, ddram_we;
    logic [`PGM_ADDR_W-1:0]             ddram_addr;
    logic [`PGM_DATA_W-1:0]             ddram_din, ddram_dout;
    logic [`PGM_BE_W-1:0]               ddram_be;
    logic                               ddram_busy, ddram_dout_ready;
    logic                               busy_en;    // Random back-pressure on/off
    int                                 seed = 32'haeca;
    int                                 timeouts = 0;
    int                                 rsp_count;
    logic [`PGM_ADDR_W-1:0]             rsp_addr;

    pgm_ddram_hub pgm_ddram_hub_i (.*);

    initial begin
        fixed_50m_clk = 1'b0;
        forever #10 fixed_50m_clk = ~fixed_50m_clk;
    end

    // DDRAM model, answers 2 to 6 cycles after each rd
    always @(posedge fixed_50m_clk) begin
        ddram_busy <= busy_en && (($random(seed) & 3) == 0);
        ddram_dout_ready <= 1'b0;
        if (reset) begin
            rsp_count <= 0;
        end else if (ddram_rd) begin
            rsp_addr  <= ddram_addr;
            rsp_count <= 2 + int'($unsigned($random(seed)) % 5);
        end else if (rsp_count == 1) begin
            ddram_dout_ready <= 1'b1;
            ddram_dout       <= {35'd0, rsp_addr} ^ RESP_XOR;
            rsp_count        <= 0;
        end else if (rsp_count != 0) begin
            rsp_count <= rsp_count - 1;
        end
    end

    task automatic loader_write(input logic [`PGM_IOCTL_ADDR_W-1:0] addr,
                                input logic [15:0] data, input logic [7:0] index);
        int n;
        @(posedge fixed_50m_clk);
        ioctl_wr    <= 1'b1;
        ioctl_addr  <= addr;
        ioctl_dout  <= data;
        ioctl_index <= index;
        @(posedge fixed_50m_clk);
        ioctl_wr <= 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin     // Held off while the write is pending
            @(posedge fixed_50m_clk);
            if (!ioctl_wait)
                break;
        end
        if (n == TIMEOUT) begin
            timeouts++;
            $display("Timeout waiting for ioctl_wait to clear");
        end
    endtask

    task automatic wait_ack(input int idx, input logic level);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge fixed_50m_clk);
            if (client_resp[idx].ack == level)
                break;
        end
        if (n == TIMEOUT) begin
            timeouts++;
            $display("Timeout waiting for ack of client %0d to reach %0d", idx, level);
        end
    endtask

    task automatic raise_req(input int idx, input logic [`PGM_ADDR_W-1:0] addr);
        client_req[idx].req  <= 1'b1;
        client_req[idx].addr <= addr;
    endtask

    task automatic client_read(input int idx, input logic [`PGM_ADDR_W-1:0] addr);
        @(posedge fixed_50m_clk);
        raise_req(idx, addr);
        wait_ack(idx, 1'b1);
        repeat (2) @(posedge fixed_50m_clk);    // Ack must hold while req stays up
        client_req[idx].req <= 1'b0;
        wait_ack(idx, 1'b0);
    endtask

    initial begin
        int errors;
        reset = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_index = '0;
        ddram_dout = '0;
        ddram_busy = 1'b0;
        ddram_dout_ready = 1'b0;
        busy_en = 1'b0;
        for (int i = 0; i < `PGM_NUM_CLIENTS; i++)
            client_req[i] = '0;
        repeat (16) @(posedge fixed_50m_clk);
        reset <= 1'b0;
        repeat (4) @(posedge fixed_50m_clk);

        // Download with back-pressure, one request parked until it ends
        busy_en <= 1'b1;
        ioctl_download <= 1'b1;
        raise_req(1, 29'h0123456);
        for (int k = 0; k < 8; k++)
            loader_write(27'(k * 2 + 27'h1000), 16'($random(seed)), 8'd0);
        loader_write(27'h2006, 16'hbeef, 8'd1);  // Other image, ignored
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b0;
        wait_ack(1, 1'b1);
        client_req[1].req <= 1'b0;
        wait_ack(1, 1'b0);

        for (int i = 0; i < `PGM_NUM_CLIENTS; i++)
            client_read(i, 29'($random(seed)));

        // Race between clients 0 and 2
        repeat (3) @(posedge fixed_50m_clk);
        raise_req(0, 29'h1abcdef);
        raise_req(2, 29'h0fedcba);
        wait_ack(0, 1'b1);
        wait_ack(2, 1'b1);
        client_req[0].req <= 1'b0;
        client_req[2].req <= 1'b0;
        wait_ack(0, 1'b0);
        wait_ack(2, 1'b0);

        for (int k = 0; k < 20; k++)
            client_read(int'($unsigned($random(seed)) % `PGM_NUM_CLIENTS), 29'($random(seed)));
        repeat (5) @(posedge fixed_50m_clk);

        errors = pgm_ddram_hub_i.checks_i.fail_count;
        $display("Errors: assertions %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== pgm_ddram_hub.f ====
+incdir+include
hw/pgm_ddram_pkg.sv
hw/read_slot.sv
hw/grant_arbiter.sv
hw/loader_write_latch.sv
hw/ddram_sequencer.sv
hw/pgm_ddram_hub.sv
tb/pgm_ddram_hub_assertions.sv
tb/tb_pgm_ddram_hub.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DDRAM hub testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f pgm_ddram_hub.f \
    --top-module tb_pgm_ddram_hub \
    -o sim_pgm_ddram_hub
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Keep running past the first assertion so the summary line is printed
output=$(./obj_dir/sim_pgm_ddram_hub +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
